//--- logic/ccir656_decode.sv
module ccir656_decode (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [ntsc_pkg::COMP_W-1:0] tv_in_ycrcb,
  output logic                        pix_valid,
  output logic [ntsc_pkg::COMP_W-1:0] pix_y,
  output logic [ntsc_pkg::COMP_W-1:0] pix_cr,
  output logic [ntsc_pkg::COMP_W-1:0] pix_cb,
  output logic                        sync_v,
  output logic                        sync_h,
  output logic                        field
);
  import ntsc_pkg::*;

  // Hunt for 000 000, then the XY word, then Cb Y Cr Y until the next 3FF
  typedef enum logic [2:0] {
    HUNT,
    ZERO_1,
    XY_WORD,
    ACT_CB,
    ACT_Y0,
    ACT_CR,
    ACT_Y1
  } state_t;

  state_t state;
  state_t state_next;
  logic   is_preamble;
  logic   is_zero;
  logic   xy_known;
  logic   xy_accept;
  logic   xy_active;
  logic   y_word;

  assign is_preamble = (tv_in_ycrcb == WORD_PREAMBLE);
  assign is_zero     = (tv_in_ycrcb == WORD_ZERO);

  // Compare against the table of legal XY words
  always_comb
  begin
    xy_known = 1'b0;
    for (int i = 0; i < XY_CODE_COUNT; i++)
    begin
      if (tv_in_ycrcb == XY_CODES[i])
        xy_known = 1'b1;
    end
  end

  assign xy_accept = (state == XY_WORD) && xy_known;
  // Active video has neither V nor H set (200 and 31C)
  assign xy_active = !tv_in_ycrcb[V_BIT] && !tv_in_ycrcb[H_BIT];
  assign y_word    = ((state == ACT_Y0) || (state == ACT_Y1)) && !is_preamble;

  always_comb
  begin
    state_next = HUNT;
    // 3FF always restarts the hunt
    if (!is_preamble)
      case (state)
        HUNT:    state_next = is_zero ? ZERO_1 : HUNT;
        ZERO_1:  state_next = is_zero ? XY_WORD : HUNT;
        // Blanking and unknown codes drop back to the hunt
        XY_WORD: state_next = (xy_accept && xy_active) ? ACT_CB : HUNT;
        ACT_CB:  state_next = ACT_Y0;
        ACT_Y0:  state_next = ACT_CR;
        ACT_CR:  state_next = ACT_Y1;
        ACT_Y1:  state_next = ACT_CB;
        default: state_next = HUNT;
      endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= HUNT;
      pix_valid <= 1'b0;
      sync_v    <= 1'b0;
      sync_h    <= 1'b0;
      field     <= 1'b0;
    end
    else
    begin
      state     <= state_next;
      pix_valid <= y_word;
      // Sync pulses last one cycle, field holds until the next XY word
      sync_v    <= xy_accept && tv_in_ycrcb[V_BIT];
      sync_h    <= xy_accept && tv_in_ycrcb[H_BIT];
      if (xy_accept)
        field <= tv_in_ycrcb[FIELD_BIT];
    end
  end

  // Component registers, Y goes out with the strobe
  always_ff @(posedge clk)
  begin
    if (y_word)
      pix_y <= tv_in_ycrcb;
    if ((state == ACT_CR) && !is_preamble)
      pix_cr <= tv_in_ycrcb;
    if ((state == ACT_CB) && !is_preamble)
      pix_cb <= tv_in_ycrcb;
  end

  // At least one chroma word sits between two Y words
  a_pix_valid_spaced: assert property (
    @(posedge clk) disable iff (reset) pix_valid |=> !pix_valid
  ) else $error("pix_valid high on two consecutive cycles");

endmodule

//--- logic/chroma_classifier.sv
module chroma_classifier (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        px_valid,
  input  logic [ntsc_pkg::COMP_W-1:0] px_cr,
  input  logic [ntsc_pkg::COMP_W-1:0] px_cb,
  input  logic [ntsc_pkg::X_W-1:0]    px_x,
  input  logic [ntsc_pkg::Y_W-1:0]    px_line,
  output ntsc_pkg::color_t            color,
  output logic [ntsc_pkg::X_W-1:0]    interesting_x,
  output logic [ntsc_pkg::Y_W-1:0]    interesting_y,
  output logic                        interesting_flag
);
  import ntsc_pkg::*;

  logic   cr_high;
  logic   cr_low;
  logic   cb_high;
  logic   cb_low;
  logic   corner;
  color_t corner_color;

  // Strict compares, the thresholds themselves are mid-range
  assign cr_high = px_cr > CHROMA_HIGH;
  assign cr_low  = px_cr < CHROMA_LOW;
  assign cb_high = px_cb > CHROMA_HIGH;
  assign cb_low  = px_cb < CHROMA_LOW;

  // Priority follows the encoding order of color_t
  always_comb
  begin
    corner       = 1'b1;
    corner_color = HIGH_HIGH;
    if (cr_high && cb_high)
      corner_color = HIGH_HIGH;
    else if (cr_low && cb_high)
      corner_color = LOW_HIGH;
    else if (cr_high && cb_low)
      corner_color = HIGH_LOW;
    else if (cr_low && cb_low)
      corner_color = LOW_LOW;
    else
      corner = 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      interesting_flag <= 1'b0;
    else
      interesting_flag <= px_valid && corner;
  end

  // Last hit is held until the next one
  always_ff @(posedge clk)
  begin
    if (px_valid && corner)
    begin
      color         <= corner_color;
      interesting_x <= px_x;
      interesting_y <= px_line;
    end
  end

  a_flag_follows_pixel: assert property (
    @(posedge clk) disable iff (reset) interesting_flag |-> $past(px_valid)
  ) else $error("interesting_flag without a pixel on the previous cycle");

endmodule

//--- logic/ntsc_capture.sv
module ntsc_capture #(
  parameter int ACTIVE_WIDTH = 640,
  parameter int ACTIVE_LINES = 480
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [ntsc_pkg::COMP_W-1:0] tv_in_ycrcb,
  output logic [ntsc_pkg::PAIR_W-1:0] ntsc_pixels,
  output logic                        ntsc_flag,
  output ntsc_pkg::color_t            color,
  output logic [ntsc_pkg::X_W-1:0]    interesting_x,
  output logic [ntsc_pkg::Y_W-1:0]    interesting_y,
  output logic                        interesting_flag,
  output logic                        frame_flag,
  output logic                        dv,
  output logic [2:0]                  fvh,
  output logic [ntsc_pkg::X_W-1:0]    x,
  output logic [ntsc_pkg::Y_W-1:0]    y
);
  import ntsc_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Decoder outputs
  ////////////////////////////////////////////////////////////////////////////

  logic              pix_valid;
  logic [COMP_W-1:0] pix_y;
  logic [COMP_W-1:0] pix_cr;
  logic [COMP_W-1:0] pix_cb;
  logic              sync_v;
  logic              sync_h;
  logic              field;

  // Tracker outputs, shared by packer and classifier
  logic              px_valid;
  logic [COMP_W-1:0] px_y;
  logic [COMP_W-1:0] px_cr;
  logic [COMP_W-1:0] px_cb;
  logic [X_W-1:0]    px_x;
  logic [Y_W-1:0]    px_line;

  // Raw decoder status, field on top
  assign dv  = pix_valid;
  assign fvh = {field, sync_v, sync_h};

  ccir656_decode decode (
    .clk         (clk),
    .reset       (reset),
    .tv_in_ycrcb (tv_in_ycrcb),
    .pix_valid   (pix_valid),
    .pix_y       (pix_y),
    .pix_cr      (pix_cr),
    .pix_cb      (pix_cb),
    .sync_v      (sync_v),
    .sync_h      (sync_h),
    .field       (field)
  );

  raster_tracker #(
    .ACTIVE_WIDTH (ACTIVE_WIDTH),
    .ACTIVE_LINES (ACTIVE_LINES)
  ) tracker (
    .clk        (clk),
    .reset      (reset),
    .pix_valid  (pix_valid),
    .pix_y      (pix_y),
    .pix_cr     (pix_cr),
    .pix_cb     (pix_cb),
    .sync_v     (sync_v),
    .sync_h     (sync_h),
    .field      (field),
    .px_valid   (px_valid),
    .px_y       (px_y),
    .px_cr      (px_cr),
    .px_cb      (px_cb),
    .px_x       (px_x),
    .px_line    (px_line),
    .x          (x),
    .y          (y),
    .frame_flag (frame_flag)
  );

  pixel_packer packer (
    .clk         (clk),
    .reset       (reset),
    .px_valid    (px_valid),
    .px_y        (px_y),
    .px_cr       (px_cr),
    .px_cb       (px_cb),
    .ntsc_pixels (ntsc_pixels),
    .ntsc_flag   (ntsc_flag)
  );

  chroma_classifier classifier (
    .clk              (clk),
    .reset            (reset),
    .px_valid         (px_valid),
    .px_cr            (px_cr),
    .px_cb            (px_cb),
    .px_x             (px_x),
    .px_line          (px_line),
    .color            (color),
    .interesting_x    (interesting_x),
    .interesting_y    (interesting_y),
    .interesting_flag (interesting_flag)
  );

endmodule

//--- logic/ntsc_pkg.sv
package ntsc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Stream and coordinate widths
  ////////////////////////////////////////////////////////////////////////////

  // One CCIR656 word, also one Y, Cr or Cb sample
  parameter int COMP_W = 10;
  parameter int X_W    = 10;
  parameter int Y_W    = 9;

  // Reduced pixel is Y[9:2], Cr[9:5], Cb[9:5]
  parameter int PIX_W  = 18;
  parameter int PAIR_W = 2 * PIX_W;

  ////////////////////////////////////////////////////////////////////////////
  // Timing reference codes
  ////////////////////////////////////////////////////////////////////////////

  parameter logic [COMP_W-1:0] WORD_PREAMBLE = 10'h3FF;
  parameter logic [COMP_W-1:0] WORD_ZERO     = 10'h000;

  // The eight XY words that follow 3FF 000 000
  parameter int XY_CODE_COUNT = 8;
  parameter logic [COMP_W-1:0] XY_CODES [XY_CODE_COUNT] = '{
    10'h200, 10'h274, 10'h2AC, 10'h2D8,
    10'h31C, 10'h368, 10'h3B0, 10'h3C4
  };

  // Flag positions inside an XY word
  parameter int FIELD_BIT = 8;
  parameter int V_BIT     = 7;
  parameter int H_BIT     = 6;

  ////////////////////////////////////////////////////////////////////////////
  // Chroma corners
  ////////////////////////////////////////////////////////////////////////////

  parameter logic [COMP_W-1:0] CHROMA_HIGH = 10'd800;
  parameter logic [COMP_W-1:0] CHROMA_LOW  = 10'd200;

  // Corner names read Cr first, then Cb
  typedef enum logic [1:0] {
    HIGH_HIGH = 2'd0,
    LOW_HIGH  = 2'd1,
    HIGH_LOW  = 2'd2,
    LOW_LOW   = 2'd3
  } color_t;

endpackage

//--- logic/pixel_packer.sv
module pixel_packer (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        px_valid,
  input  logic [ntsc_pkg::COMP_W-1:0] px_y,
  input  logic [ntsc_pkg::COMP_W-1:0] px_cr,
  input  logic [ntsc_pkg::COMP_W-1:0] px_cb,
  output logic [ntsc_pkg::PAIR_W-1:0] ntsc_pixels,
  output logic                        ntsc_flag
);
  import ntsc_pkg::*;

  logic             slot_high;
  logic [PIX_W-1:0] reduced;

  // Keep the top 8 bits of Y and the top 5 of each chroma
  assign reduced = {px_y[COMP_W-1 -: 8], px_cr[COMP_W-1 -: 5], px_cb[COMP_W-1 -: 5]};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      slot_high <= 1'b0;
      ntsc_flag <= 1'b0;
    end
    else
    begin
      // Word is complete once the upper half is written
      ntsc_flag <= px_valid && slot_high;
      if (px_valid)
        slot_high <= !slot_high;
    end
  end

  always_ff @(posedge clk)
  begin
    if (px_valid)
    begin
      if (slot_high)
        ntsc_pixels[PAIR_W-1:PIX_W] <= reduced;
      else
        ntsc_pixels[PIX_W-1:0] <= reduced;
    end
  end

endmodule

//--- logic/raster_tracker.sv
module raster_tracker #(
  parameter int ACTIVE_WIDTH = 640,
  parameter int ACTIVE_LINES = 480
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        pix_valid,
  input  logic [ntsc_pkg::COMP_W-1:0] pix_y,
  input  logic [ntsc_pkg::COMP_W-1:0] pix_cr,
  input  logic [ntsc_pkg::COMP_W-1:0] pix_cb,
  input  logic                        sync_v,
  input  logic                        sync_h,
  input  logic                        field,
  output logic                        px_valid,
  output logic [ntsc_pkg::COMP_W-1:0] px_y,
  output logic [ntsc_pkg::COMP_W-1:0] px_cr,
  output logic [ntsc_pkg::COMP_W-1:0] px_cb,
  output logic [ntsc_pkg::X_W-1:0]    px_x,
  output logic [ntsc_pkg::Y_W-1:0]    px_line,
  output logic [ntsc_pkg::X_W-1:0]    x,
  output logic [ntsc_pkg::Y_W-1:0]    y,
  output logic                        frame_flag
);
  import ntsc_pkg::*;

  logic in_window;
  logic forward;
  logic frame_done;

  // Lines past the window are blanking and pixels past the width are dropped
  assign in_window = (x < ACTIVE_WIDTH) && (y < ACTIVE_LINES);
  assign forward   = pix_valid && in_window;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      x          <= '0;
      y          <= '0;
      px_valid   <= 1'b0;
      frame_flag <= 1'b0;
      frame_done <= 1'b0;
    end
    else
    begin
      px_valid <= forward;
      // Field 1 takes the even lines and field 0 the odd lines
      if (sync_v)
      begin
        y <= field ? '0 : Y_W'(1);
        x <= '0;
      end
      else if (sync_h)
      begin
        y <= y + Y_W'(2);
        x <= '0;
      end
      else if (forward)
        x <= x + 1'b1;

      // One pulse per frame that rearms once field goes back to 0
      frame_flag <= sync_v && field && !frame_done;
      if (!field)
        frame_done <= 1'b0;
      else if (sync_v)
        frame_done <= 1'b1;
    end
  end

  // Pixel stage register with its coordinates
  always_ff @(posedge clk)
  begin
    if (forward)
    begin
      px_y    <= pix_y;
      px_cr   <= pix_cr;
      px_cb   <= pix_cb;
      px_x    <= x;
      px_line <= y;
    end
  end

  a_x_bounded: assert property (
    @(posedge clk) disable iff (reset) x <= ACTIVE_WIDTH
  ) else $error("x ran past the active width");

endmodule

//--- ntsc_capture.f
+incdir+test
logic/ntsc_pkg.sv
logic/ccir656_decode.sv
logic/raster_tracker.sv
logic/pixel_packer.sv
logic/chroma_classifier.sv
logic/ntsc_capture.sv
test/ntsc_capture_tb.sv

//--- test/ccir656_stream.svh
`ifndef CCIR656_STREAM_SVH
`define CCIR656_STREAM_SVH

// Model state that mirrors what the capture path should hold
logic [9:0]  exp_x = '0;
logic [8:0]  exp_y = '0;
logic [9:0]  last_cr = 'x;
logic [9:0]  last_cb = 'x;
logic        slot = 1'b0;
logic [17:0] low_half;
int          exp_frames = 0;
logic        frame_done_m = 1'b0;
logic        dv_ok = 1'b0;
// Field, V and H as the decoder should show them for this word
logic [2:0]  exp_fvh = 3'b000;

// Expected results in order of arrival
logic [35:0] pair_q[$];
logic [1:0]  color_q[$];
logic [18:0] coord_q[$];

// One stream word per clock set up on the falling edge
task automatic send_word(input logic [9:0] w);
  @(negedge clk);
  tv_in_ycrcb = w;
  // Sync pulses belong to the XY word only
  exp_fvh[1:0] = 2'b00;
  if (w == 10'h3FF)
    dv_ok = 1'b0;
endtask

// Blank level is harmless while the decoder hunts
task automatic idle(input int n);
  repeat (n) send_word(10'h040);
endtask

// Coordinate and frame rules for an accepted XY word
task automatic model_xy(input logic [9:0] code);
  if (code[7])
  begin
    exp_y = code[8] ? 9'd0 : 9'd1;
    exp_x = '0;
  end
  else if (code[6])
  begin
    exp_y = exp_y + 9'd2;
    exp_x = '0;
  end
  if (code[7] && code[8] && !frame_done_m)
    exp_frames++;
  if (!code[8])
    frame_done_m = 1'b0;
  else if (code[7])
    frame_done_m = 1'b1;
endtask

// Preamble, two zeros, then the XY word
task automatic send_xy(input logic [9:0] code);
  logic known;
  known = code inside {10'h200, 10'h274, 10'h2AC, 10'h2D8,
                       10'h31C, 10'h368, 10'h3B0, 10'h3C4};
  send_word(10'h3FF);
  send_word(10'h000);
  send_word(10'h000);
  send_word(code);
  if (known)
  begin
    // Field bit on top, then V and H
    exp_fvh = code[8:6];
    // No V and no H means a line of active video follows
    dv_ok = !code[7] && !code[6];
    model_xy(code);
  end
endtask

// Reduction, packing order and corner sort for one Y word
task automatic model_pixel(input logic [9:0] yv);
  logic [17:0] r;
  logic [1:0]  c;
  logic        hit;
  if (exp_x < 640 && exp_y < 480)
  begin
    r = {yv[9:2], last_cr[9:5], last_cb[9:5]};
    if (slot)
      pair_q.push_back({r, low_half});
    else
      low_half = r;
    slot = !slot;
    hit = 1'b1;
    c = 2'd0;
    if (last_cr > 800 && last_cb > 800)
      c = 2'd0;
    else if (last_cr < 200 && last_cb > 800)
      c = 2'd1;
    else if (last_cr > 800 && last_cb < 200)
      c = 2'd2;
    else if (last_cr < 200 && last_cb < 200)
      c = 2'd3;
    else
      hit = 1'b0;
    if (hit)
    begin
      color_q.push_back(c);
      coord_q.push_back({exp_x, exp_y});
    end
    exp_x = exp_x + 10'd1;
  end
endtask

// Cb Y Cr Y where the first Y still pairs with the previous Cr
task automatic send_group(input logic [9:0] cr, input logic [9:0] cb,
                          input logic [9:0] y0, input logic [9:0] y1);
  send_word(cb);
  last_cb = cb;
  send_word(y0);
  model_pixel(y0);
  send_word(cr);
  last_cr = cr;
  send_word(y1);
  model_pixel(y1);
endtask

`endif

//--- test/ntsc_capture_tb.sv
module ntsc_capture_tb;

  // Stream length of all tests rounded up
  localparam int TOTAL_WORDS    = 160;
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_WORDS + 100;

  logic        clk;
  logic        reset;
  logic [9:0]  tv_in_ycrcb;
  logic [35:0] ntsc_pixels;
  logic        ntsc_flag;
  logic [1:0]  color;
  logic [9:0]  interesting_x;
  logic [8:0]  interesting_y;
  logic        interesting_flag;
  logic        frame_flag;
  logic        dv;
  logic [2:0]  fvh;
  logic [9:0]  x;
  logic [8:0]  y;

  int errors = 0;
  int err_mark = 0;
  int pass_count = 0;
  int fail_count = 0;
  int cycles = 0;
  int frames_seen = 0;
  int seed = 30;

  `include "ccir656_stream.svh"

  ntsc_capture #(
    .ACTIVE_WIDTH (640),
    .ACTIVE_LINES (480)
  ) uut (
    .clk              (clk),
    .reset            (reset),
    .tv_in_ycrcb      (tv_in_ycrcb),
    .ntsc_pixels      (ntsc_pixels),
    .ntsc_flag        (ntsc_flag),
    .color            (color),
    .interesting_x    (interesting_x),
    .interesting_y    (interesting_y),
    .interesting_flag (interesting_flag),
    .frame_flag       (frame_flag),
    .dv               (dv),
    .fvh              (fvh),
    .x                (x),
    .y                (y)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
    begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Queue heads that move on after each flag has been checked
  ////////////////////////////////////////////////////////////////////////////

  logic        pop_pair = 1'b0;
  logic        pop_hit = 1'b0;
  logic        pair_ok = 1'b0;
  logic        hit_ok = 1'b0;
  logic [35:0] head_pair = '0;
  logic [1:0]  head_color = '0;
  logic [18:0] head_coord = '0;

  always @(negedge clk)
  begin
    if (pop_pair && pair_q.size() > 0)
      void'(pair_q.pop_front());
    if (pop_hit && color_q.size() > 0)
    begin
      void'(color_q.pop_front());
      void'(coord_q.pop_front());
    end
    pop_pair = (ntsc_flag === 1'b1);
    pop_hit = (interesting_flag === 1'b1);
    pair_ok = pair_q.size() > 0;
    hit_ok = color_q.size() > 0;
    head_pair = pair_ok ? pair_q[0] : '0;
    head_color = hit_ok ? color_q[0] : '0;
    head_coord = hit_ok ? coord_q[0] : '0;
    // A one-cycle pulse spans exactly one falling edge
    if (frame_flag === 1'b1)
      frames_seen++;
  end

  // Expected fvh delayed to the edge that follows its stream word
  logic [2:0] fvh_due = 3'b000;

  always @(posedge clk)
    fvh_due <= exp_fvh;

  ////////////////////////////////////////////////////////////////////////////
  // Checking assertions
  ////////////////////////////////////////////////////////////////////////////

  a_pair_expected: assert property (@(posedge clk) disable iff (reset)
    ntsc_flag |-> pair_ok)
  else
  begin
    errors++;
    $display("ntsc_flag rose with no packed word expected");
  end

  a_pair_value: assert property (@(posedge clk) disable iff (reset)
    ntsc_flag && pair_ok |-> ntsc_pixels === head_pair)
  else
  begin
    errors++;
    $display("mismatch ntsc_pixels: got %h expected %h", $sampled(ntsc_pixels),
             $sampled(head_pair));
  end

  a_hit_expected: assert property (@(posedge clk) disable iff (reset)
    interesting_flag |-> hit_ok)
  else
  begin
    errors++;
    $display("interesting_flag rose for a pixel outside the corners");
  end

  a_color_value: assert property (@(posedge clk) disable iff (reset)
    interesting_flag && hit_ok |-> color === head_color)
  else
  begin
    errors++;
    $display("mismatch color: got %h expected %h", $sampled(color), $sampled(head_color));
  end

  a_hit_x: assert property (@(posedge clk) disable iff (reset)
    interesting_flag && hit_ok |-> interesting_x === head_coord[18:9])
  else
  begin
    errors++;
    $display("mismatch interesting_x: got %h expected %h", $sampled(interesting_x),
             $sampled(head_coord[18:9]));
  end

  a_hit_y: assert property (@(posedge clk) disable iff (reset)
    interesting_flag && hit_ok |-> interesting_y === head_coord[8:0])
  else
  begin
    errors++;
    $display("mismatch interesting_y: got %h expected %h", $sampled(interesting_y),
             $sampled(head_coord[8:0]));
  end

  // dv and sync lag their stream word by one edge
  a_dv_allowed: assert property (@(posedge clk) disable iff (reset)
    dv |-> $past(dv_ok))
  else
  begin
    errors++;
    $display("dv went high outside an active line");
  end

  // Field level and both sync pulses on every cycle
  a_fvh_value: assert property (@(posedge clk) disable iff (reset)
    fvh === fvh_due)
  else
  begin
    errors++;
    $display("mismatch fvh: got %h expected %h", $sampled(fvh), $sampled(fvh_due));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [9:0] filler_chroma();
    filler_chroma = 10'(200 + ({$random(seed)} % 601));
  endfunction

  task automatic end_test(input string name);
    if (errors == err_mark)
    begin
      pass_count++;
      $display("test %s passed", name);
    end
    else
    begin
      fail_count++;
      $display("test %s failed with %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic check_coords();
    idle(3);
    assert (y === exp_y)
    else
    begin
      errors++;
      $display("mismatch y: got %h expected %h", y, exp_y);
    end
    assert (x === exp_x)
    else
    begin
      errors++;
      $display("mismatch x: got %h expected %h", x, exp_x);
    end
  endtask

  task automatic check_frames();
    idle(3);
    assert (frames_seen == exp_frames)
    else
    begin
      errors++;
      $display("mismatch frame_flag count: got %h expected %h", frames_seen, exp_frames);
    end
  endtask

  initial
  begin
    reset = 1'b1;
    tv_in_ycrcb = 10'h040;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Reset state and then blanking with no active XY word
    assert (!dv && !ntsc_flag && !interesting_flag && !frame_flag && fvh === 3'b000)
    else
    begin
      errors++;
      $display("a flag is not low after reset");
    end
    assert (x === '0 && y === '0)
    else
    begin
      errors++;
      $display("mismatch x y: got %h %h expected 0 0", x, y);
    end
    idle(4);
    end_test("reset");

    // Packing of eight known luma values with filler chroma
    send_xy(10'h274);
    send_xy(10'h200);
    for (int i = 0; i < 4; i++)
      send_group(filler_chroma(), filler_chroma(), 10'(10'h100 + 74 * i),
                 10'(10'h120 + 74 * i));
    send_word(10'h3FF);
    idle(4);
    end_test("packing");

    // Each corner and then mid-range chroma
    send_xy(10'h274);
    send_xy(10'h200);
    send_group(10'd900, 10'd900, 10'h180, 10'h190);
    send_group(10'd100, 10'd900, 10'h1A0, 10'h1B0);
    send_group(10'd900, 10'd100, 10'h1C0, 10'h1D0);
    send_group(10'd100, 10'd100, 10'h1E0, 10'h1F0);
    send_group(10'd500, 10'd500, 10'h200, 10'h210);
    send_word(10'h3FF);
    idle(4);
    end_test("classify");

    // H only and then V in field 0 and field 1
    send_xy(10'h274);
    check_coords();
    send_xy(10'h2AC);
    check_coords();
    send_xy(10'h3B0);
    check_coords();
    end_test("coordinates");

    send_xy(10'h3B0);
    check_frames();
    send_xy(10'h3C4);
    check_frames();
    send_xy(10'h2AC);
    check_frames();
    send_xy(10'h3B0);
    check_frames();
    end_test("frame");

    // Preamble in the middle of a line and then an unknown XY word
    send_xy(10'h368);
    send_xy(10'h200);
    send_group(filler_chroma(), filler_chroma(), 10'h150, 10'h160);
    // Cb and first Y of a group that the preamble cuts short
    last_cb = filler_chroma();
    send_word(last_cb);
    send_word(10'h170);
    model_pixel(10'h170);
    send_word(10'h3FF);
    idle(4);
    send_xy(10'h2C0);
    check_coords();
    send_xy(10'h200);
    send_group(filler_chroma(), filler_chroma(), 10'h240, 10'h250);
    send_word(10'h3FF);
    idle(8);
    assert (pair_q.size() == 0 && color_q.size() == 0)
    else
    begin
      errors++;
      $display("expected results never came out of the DUT");
    end
    end_test("resync");

    $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
